// File: build.f
rtl/dcp_types_pkg.sv
rtl/dcp_codes_pkg.sv
rtl/dcp_regfile.sv
rtl/dcp_cmd_decode.sv
rtl/dcp_reg_dump.sv
rtl/dcp_tx_format.sv
rtl/dcp_top.sv
test/dcp_properties.sv
test/dcp_tb.sv

// File: rtl/dcp_cmd_decode.sv
`timescale 1ns/1ps

module dcp_cmd_decode
    import dcp_types_pkg::*;
    import dcp_codes_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  char_t rx_byte,
    input  logic  rx_strobe,
    input  logic  dump_done,
    output mode_t mode
);

    logic is_idle;
    logic start_dump;

    assign is_idle    = (mode == mode_idle);
    assign start_dump = rx_strobe && (rx_byte == cmd_dump_regs);

    // Mode is held for the whole dump so the sequencer sees a stable input.
    // Anything received while a dump runs is dropped.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mode <= mode_idle;
        end else if (is_idle) begin
            if (start_dump) begin
                mode <= mode_dump_regs;
            end
        end else if (dump_done) begin
            mode <= mode_idle;  // Back to idle the cycle after done
        end
    end

endmodule

// File: rtl/dcp_codes_pkg.sv
package dcp_codes_pkg;

    import dcp_types_pkg::*;

    // ASCII characters used in the dump text
    localparam char_t ascii_r    = 8'h52;
    localparam char_t ascii_eq   = 8'h3D;
    localparam char_t ascii_zero = 8'h30;
    localparam char_t ascii_a    = 8'h41;
    localparam char_t ascii_cr   = 8'h0D;
    localparam char_t ascii_lf   = 8'h0A;

    localparam char_t cmd_dump_regs = ascii_r;  // Host command for a register dump

    // Console modes; the dump mode reuses its command code
    localparam mode_t mode_idle      = 8'h00;
    localparam mode_t mode_dump_regs = cmd_dump_regs;

endpackage

// File: rtl/dcp_reg_dump.sv
`timescale 1ns/1ps

module dcp_reg_dump
    import dcp_types_pkg::*;
    import dcp_codes_pkg::*;
#(
    parameter int NUM_REGS = 32,
    localparam int AW = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1
) (
    input  logic          clk,
    input  logic          rstn,
    input  mode_t         mode,
    output logic [AW-1:0] rd_addr,
    input  word_t         rd_data,
    output logic          tx_req,
    output logic          tx_is_word,
    output word_t         tx_data,
    input  logic          tx_ack,
    output logic          dump_done
);

    localparam logic [AW-1:0] LAST_ADDR = AW'(NUM_REGS - 1);

    dump_state_t   state;
    dump_state_t   state_nxt;
    logic [AW-1:0] cur_addr;
    logic          lf_sent;    // CR already acknowledged in finish
    logic          active;
    char_t         addr_char;

    assign active    = (mode == mode_dump_regs);
    assign rd_addr   = cur_addr;
    assign dump_done = (state == dump_finish) && lf_sent && tx_ack;

    // 0-9 then A-V for a 32-entry file
    always_comb begin
        if (char_t'(cur_addr) < 8'd10) begin
            addr_char = ascii_zero + char_t'(cur_addr);
        end else begin
            addr_char = ascii_a + char_t'(cur_addr) - 8'd10;
        end
    end

    always_comb begin
        state_nxt  = state;
        tx_is_word = 1'b0;
        tx_data    = '0;
        case (state)
            dump_idle: begin
                if (active) state_nxt = dump_print_r;
            end
            dump_print_r: begin
                tx_data = word_t'(ascii_r);
                if (tx_ack) state_nxt = dump_print_addr;
            end
            dump_print_addr: begin
                tx_data = word_t'(addr_char);
                if (tx_ack) state_nxt = dump_print_eq;
            end
            dump_print_eq: begin
                tx_data = word_t'(ascii_eq);
                if (tx_ack) state_nxt = dump_fetch;
            end
            dump_fetch: begin
                state_nxt = dump_print_data;  // Read data settles on rd_data
            end
            dump_print_data: begin
                tx_is_word = 1'b1;
                tx_data    = rd_data;
                if (tx_ack) state_nxt = dump_next_addr;
            end
            dump_next_addr: begin
                state_nxt = (cur_addr == LAST_ADDR) ? dump_finish : dump_print_r;
            end
            dump_finish: begin
                tx_data = word_t'(lf_sent ? ascii_lf : ascii_cr);
                if (tx_ack && lf_sent) state_nxt = dump_idle;
            end
            default: state_nxt = dump_idle;
        endcase
        if (!active) state_nxt = dump_idle;  // Mode left, abandon the dump
    end

    // Request drops the cycle after ack and rises again one cycle later
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= dump_idle;
            tx_req   <= 1'b0;
            cur_addr <= '0;
            lf_sent  <= 1'b0;
        end else begin
            state <= state_nxt;
            case (state)
                dump_idle: begin
                    tx_req   <= active;
                    cur_addr <= '0;
                    lf_sent  <= 1'b0;
                end
                dump_print_r, dump_print_addr, dump_print_eq, dump_print_data: begin
                    tx_req <= !tx_ack;
                end
                dump_fetch: begin
                    tx_req <= 1'b1;
                end
                dump_next_addr: begin
                    tx_req   <= 1'b1;
                    cur_addr <= cur_addr + 1'b1;
                end
                dump_finish: begin
                    tx_req <= !tx_ack;
                    if (tx_ack) lf_sent <= 1'b1;
                end
                default: tx_req <= 1'b0;
            endcase
            if (!active) tx_req <= 1'b0;
        end
    end

endmodule

// File: rtl/dcp_regfile.sv
`timescale 1ns/1ps

module dcp_regfile
    import dcp_types_pkg::*;
#(
    parameter int NUM_REGS = 32,
    localparam int AW = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1
) (
    input  logic          clk,
    input  logic          rstn,
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  word_t         wr_data,
    input  logic [AW-1:0] rd_addr,
    output word_t         rd_data
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rd_data = regs[rd_addr];  // Same-cycle read for the dump sequencer

endmodule

// File: rtl/dcp_top.sv
`timescale 1ns/1ps

module dcp_top
    import dcp_types_pkg::*;
#(
    parameter int NUM_REGS = 32,
    localparam int AW = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1
) (
    input  logic          clk,
    input  logic          rstn,
    input  char_t         rx_byte,
    input  logic          rx_strobe,
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  word_t         wr_data,
    input  logic          tx_busy,
    output char_t         tx_byte,
    output logic          tx_strobe,
    output logic          dump_done
);

    mode_t         mode;
    logic [AW-1:0] rd_addr;
    word_t         rd_data;
    logic          tx_req;
    logic          tx_is_word;
    word_t         tx_data;
    logic          tx_ack;

    dcp_regfile #(.NUM_REGS(NUM_REGS)) u_regfile (
        .clk     (clk),
        .rstn    (rstn),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    dcp_cmd_decode u_cmd_decode (
        .clk       (clk),
        .rstn      (rstn),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe),
        .dump_done (dump_done),
        .mode      (mode)
    );

    dcp_reg_dump #(.NUM_REGS(NUM_REGS)) u_reg_dump (
        .clk        (clk),
        .rstn       (rstn),
        .mode       (mode),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .tx_req     (tx_req),
        .tx_is_word (tx_is_word),
        .tx_data    (tx_data),
        .tx_ack     (tx_ack),
        .dump_done  (dump_done)
    );

    dcp_tx_format u_tx_format (
        .clk        (clk),
        .rstn       (rstn),
        .tx_req     (tx_req),
        .tx_is_word (tx_is_word),
        .tx_data    (tx_data),
        .tx_ack     (tx_ack),
        .tx_busy    (tx_busy),
        .tx_byte    (tx_byte),
        .tx_strobe  (tx_strobe)
    );

endmodule

// File: rtl/dcp_tx_format.sv
`timescale 1ns/1ps

module dcp_tx_format
    import dcp_types_pkg::*;
    import dcp_codes_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  tx_req,
    input  logic  tx_is_word,
    input  word_t tx_data,
    output logic  tx_ack,
    input  logic  tx_busy,
    output char_t tx_byte,
    output logic  tx_strobe
);

    fmt_state_t state;
    word_t      word_q;      // Shifts left one nibble per strobe
    logic       is_word_q;
    logic [2:0] nib_cnt;
    logic [3:0] nibble;
    char_t      hex_char;
    logic       last_byte;
    logic       take_req;

    assign take_req  = (state == fmt_idle) && tx_req;
    assign nibble    = word_q[31:28];
    assign hex_char  = (nibble < 4'd10) ? ascii_zero + char_t'(nibble)
                                        : ascii_a + char_t'(nibble) - 8'd10;
    assign last_byte = !is_word_q || (nib_cnt == 3'd7);

    assign tx_byte   = is_word_q ? hex_char : word_q[7:0];
    assign tx_strobe = (state == fmt_send) && !tx_busy;  // Never while busy
    assign tx_ack    = (state == fmt_ack);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= fmt_idle;
            is_word_q <= 1'b0;
            nib_cnt   <= '0;
        end else begin
            case (state)
                fmt_idle: begin
                    if (tx_req) begin
                        state     <= fmt_send;
                        is_word_q <= tx_is_word;
                        nib_cnt   <= '0;
                    end
                end
                fmt_send: begin
                    if (tx_busy) begin
                        state <= fmt_wait_busy;
                    end else if (last_byte) begin
                        state <= fmt_ack;
                    end else begin
                        nib_cnt <= nib_cnt + 3'd1;
                    end
                end
                fmt_wait_busy: begin
                    if (!tx_busy) state <= fmt_send;
                end
                fmt_ack: begin
                    state <= fmt_idle;
                end
                default: state <= fmt_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_req) begin
            word_q <= tx_data;
        end else if (tx_strobe) begin
            word_q <= {word_q[27:0], 4'h0};
        end
    end

endmodule

// File: rtl/dcp_types_pkg.sv
package dcp_types_pkg;

    typedef logic [7:0]  char_t;  // One ASCII byte on the wire
    typedef logic [31:0] word_t;  // One register value
    typedef logic [7:0]  mode_t;  // Console mode

    typedef enum logic [2:0] {
        dump_idle       = 3'h0,
        dump_print_r    = 3'h1,
        dump_print_addr = 3'h2,
        dump_print_eq   = 3'h3,
        dump_fetch      = 3'h4,
        dump_print_data = 3'h5,
        dump_next_addr  = 3'h6,
        dump_finish     = 3'h7
    } dump_state_t;

    typedef enum logic [1:0] {
        fmt_idle      = 2'h0,
        fmt_send      = 2'h1,
        fmt_wait_busy = 2'h2,
        fmt_ack       = 2'h3
    } fmt_state_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Compile and run the register dump console testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module dcp_tb -f build.f -o dcp_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/dcp_sim > sim.log 2>&1
status=$?
cat sim.log

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -F -q '*** FAILED ***' sim.log; then
    exit 1
fi

exit 0

// File: test/dcp_properties.sv
`timescale 1ns/1ps

module dcp_properties (
    input logic clk,
    input logic rstn,
    input logic tx_req,
    input logic tx_ack,
    input logic tx_strobe
);

    ack_single_cycle: assert property (@(posedge clk) disable iff (!rstn)
        tx_ack |-> !$past(tx_ack))
        else $error("tx_ack high in two consecutive cycles");

    // The request is held for the whole transfer, up to its ack
    strobe_needs_req: assert property (@(posedge clk) disable iff (!rstn)
        tx_strobe |-> tx_req)
        else $error("tx_strobe given without a pending tx_req");

    ack_needs_req: assert property (@(posedge clk) disable iff (!rstn)
        tx_ack |-> tx_req)
        else $error("tx_ack given without tx_req");

endmodule

bind dcp_tx_format dcp_properties u_properties (
    .clk       (clk),
    .rstn      (rstn),
    .tx_req    (tx_req),
    .tx_ack    (tx_ack),
    .tx_strobe (tx_strobe)
);

// File: test/dcp_tb.sv
`timescale 1ns/1ps

module dcp_tb
    import dcp_types_pkg::*;
();

    localparam int    NUM_REGS     = 32;
    localparam int    AW           = $clog2(NUM_REGS);
    localparam int    clk_period   = 20;
    localparam int    busy_max     = 3;   // Longest busy stretch of the transmitter model
    localparam int    quiet_cycles = 40;
    localparam char_t ch_r         = "R";
    localparam char_t ch_eq        = "=";
    localparam char_t ch_cr        = 8'h0D;
    localparam char_t ch_lf        = 8'h0A;

    typedef struct packed {
        logic        busy;    // Random back-pressure
        logic        wr;      // Refill all registers first
        word_t       base;
        int          ncmd;
        char_t [3:0] cmds;
        logic        dump;    // One full dump expected
        int          mid_at;  // Extra R after this many output bytes
    } row_t;

    logic          clk;
    logic          rstn      = 1'b0;
    char_t         rx_byte   = '0;
    logic          rx_strobe = 1'b0;
    logic          wr_en     = 1'b0;
    logic [AW-1:0] wr_addr   = '0;
    word_t         wr_data   = '0;
    logic          tx_busy   = 1'b0;
    char_t         tx_byte;
    logic          tx_strobe;
    logic          dump_done;

    word_t model_regs [NUM_REGS];
    char_t exp_q [$];
    row_t  rows [$];
    logic  busy_random     = 1'b0;
    logic  done_due        = 1'b0;
    int    busy_left       = 0;
    int    byte_idx        = 0;
    int    dumps_seen      = 0;
    int    dumps_expected  = 0;
    int    watchdog_cycles = 0;

    dcp_top #(.NUM_REGS(NUM_REGS)) dut (
        .clk       (clk),
        .rstn      (rstn),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .tx_busy   (tx_busy),
        .tx_byte   (tx_byte),
        .tx_strobe (tx_strobe),
        .dump_done (dump_done)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_char(input char_t got, input char_t exp, input int idx);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t ns: output byte %0d is %h, expected %h",
                                $time, idx, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    function automatic word_t fill_value(input word_t base, input int addr);
        return base ^ (word_t'(addr) * 32'h9E37_79B9);  // Every address bit matters
    endfunction

    function automatic char_t hex_char(input logic [3:0] nib);
        string digits;
        digits = "0123456789ABCDEF";
        return char_t'(digits[nib]);
    endfunction

    function automatic char_t addr_char(input int addr);
        if (addr < 10) begin
            return char_t'(addr + 8'h30);
        end
        return char_t'(addr - 10 + 8'h41);
    endfunction

    // Text of one dump: R, address, =, eight hex digits per register, then CR LF
    function automatic void queue_dump_text();
        word_t v;
        for (int a = 0; a < NUM_REGS; a++) begin
            v = model_regs[a];
            exp_q.push_back(ch_r);
            exp_q.push_back(addr_char(a));
            exp_q.push_back(ch_eq);
            for (int d = 7; d >= 0; d--) begin
                exp_q.push_back(hex_char(v[d*4 +: 4]));
            end
        end
        exp_q.push_back(ch_cr);
        exp_q.push_back(ch_lf);
    endfunction

    task automatic write_all_regs(input word_t base);
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = fill_value(base, i);
            @(posedge clk);
            wr_en   <= 1'b1;
            wr_addr <= AW'(i);
            wr_data <= model_regs[i];
        end
        @(posedge clk);
        wr_en <= 1'b0;
    endtask

    task automatic send_cmd(input char_t c);
        @(posedge clk);
        rx_byte   <= c;
        rx_strobe <= 1'b1;
        @(posedge clk);
        rx_strobe <= 1'b0;
    endtask

    task automatic run_row(input row_t r);
        int total;
        int start_dumps;
        int k;
        busy_random = r.busy;
        if (r.wr) begin
            write_all_regs(r.base);
        end
        if (r.dump) begin
            queue_dump_text();
            dumps_expected++;
        end
        total       = exp_q.size();
        start_dumps = dumps_seen;
        for (k = 0; k < r.ncmd; k++) begin
            send_cmd(r.cmds[k]);
        end
        if (r.mid_at != 0) begin
            while (exp_q.size() > total - r.mid_at) @(posedge clk);
            send_cmd(ch_r);  // Must be ignored while the dump runs
        end
        if (r.dump) begin
            while (dumps_seen == start_dumps) @(posedge clk);
        end
        repeat (quiet_cycles) @(posedge clk);
        if (exp_q.size() != 0) begin
            abort_run($sformatf("ERROR: %0d expected output bytes were never sent", exp_q.size()));
        end
    endtask

    always @(posedge clk) begin
        if (busy_random && tx_strobe) begin
            busy_left = $urandom_range(busy_max, 0);
            tx_busy  <= (busy_left != 0);
        end else if (busy_left > 1) begin
            busy_left = busy_left - 1;
            tx_busy  <= 1'b1;
        end else begin
            busy_left = 0;
            tx_busy  <= 1'b0;
        end
    end

    // Output monitor, dump_done is due one cycle after the last byte
    always @(posedge clk) begin
        if (rstn) begin
            check_flag(dump_done, done_due, "dump_done");
            check_flag(tx_strobe && tx_busy, 1'b0, "tx_strobe while tx_busy");
            done_due = 1'b0;
            if (exp_q.size() == 0) begin
                check_flag(tx_strobe, 1'b0, "tx_strobe with no byte expected");
            end else if (tx_strobe) begin
                check_char(tx_byte, exp_q.pop_front(), byte_idx);
                byte_idx++;
                done_due = (exp_q.size() == 0);
            end
            if (dump_done) begin
                dumps_seen++;
            end
        end
    end

    initial begin
        @(posedge rstn);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run("ERROR: timeout, the register dump did not complete");
    end

    initial begin
        int    fd;
        int    n;
        int    k;
        int    col [10];
        string line;
        row_t  r;
        void'($urandom(57724));
        fd = $fopen("test/dcp_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("ERROR: cannot open test/dcp_testdata.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %h %d %h %h %h %h %d %d", col[0], col[1], col[2],
                            col[3], col[4], col[5], col[6], col[7], col[8], col[9]);
                if (n == 10) begin
                    r.busy = (col[0] != 0);
                    r.wr   = (col[1] != 0);
                    r.base = word_t'(col[2]);
                    r.ncmd = col[3];
                    for (k = 0; k < 4; k++) begin
                        r.cmds[k] = char_t'(col[4 + k]);
                    end
                    r.dump   = (col[8] != 0);
                    r.mid_at = col[9];
                    rows.push_back(r);
                end
            end
        end
        $fclose(fd);
        if (rows.size() == 0) begin
            abort_run("ERROR: no test rows found in test/dcp_testdata.txt");
        end
        // Per byte: request turnaround, the strobe and the longest busy stretch
        watchdog_cycles = rows.size() * ((NUM_REGS * 11 + 2) * (busy_max + 6)
                          + NUM_REGS + quiet_cycles + 20);
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        if (exp_q.size() == 0 && dumps_seen == dumps_expected) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run($sformatf("ERROR: %0d dumps seen, %0d expected", dumps_seen, dumps_expected));
        end
    end

endmodule

// File: test/dcp_testdata.txt
# busy wr base ncmd cmd0 cmd1 cmd2 cmd3 dump mid_at
# busy 1 = random tx_busy, wr 1 = refill registers from base, dump 1 = one full dump
0 0 00000000 0 00 00 00 00 0 0
0 1 1234ABCD 1 52 00 00 00 1 0
0 0 00000000 4 72 51 0D 0A 0 0
1 0 00000000 1 52 00 00 00 1 0
1 0 00000000 3 41 72 3D 00 0 0
1 1 0F1E2D3C 1 52 00 00 00 1 60
1 1 DEADBEEF 1 52 00 00 00 1 0
0 1 FFFFFFFF 1 52 00 00 00 1 0
